// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= udp_rx_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'test passed'

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/udp_rx_tb.sv ====
`default_nettype none

module udp_rx_tb;

	localparam logic [47:0] BOARD_MAC = 48'h000a_3501_fec0;
	localparam int          RAM_AW    = 9;
	localparam int          TIMEOUT   = 400;       // Cycles to wait for a strobe

	logic                 clk;
	logic                 reset;
	logic [7:0]           rxd;
	logic                 rx_dv;
	logic [RAM_AW-1:0]    rd_addr;
	wire logic [31:0]     rd_data;
	wire logic            frame_done;
	wire logic            frame_drop;
	wire logic [47:0]     src_mac;
	wire logic [31:0]     src_ip;
	wire logic [31:0]     dst_ip;
	wire logic [15:0]     src_port;
	wire logic [15:0]     dst_port;
	wire logic [15:0]     payload_len;
	wire logic [RAM_AW:0] word_count;

	logic [7:0]        frame_q[$];                 // Wire bytes from preamble to FCS
	logic [7:0]        pay_q[$];
	logic [15:0]       lfsr = 16'd16807;
	logic [47:0]       exp_src_mac;
	logic [31:0]       exp_src_ip;
	logic [31:0]       exp_dst_ip;
	logic [15:0]       exp_src_port;
	logic [15:0]       exp_dst_port;
	logic [15:0]       exp_len;
	logic [RAM_AW:0]   exp_wc;
	string             test_name;
	int                done_cnt = 0;
	int                drop_cnt = 0;
	int                mon_errs = 0;               // Header mismatches seen on frame_done
	int                tests_run = 0;
	int                tests_bad = 0;

	udp_rx_top #(
		.BOARD_MAC      (BOARD_MAC),
		.RAM_ADDR_WIDTH (RAM_AW)
	) UUT (
		.clk         (clk),
		.reset       (reset),
		.rxd         (rxd),
		.rx_dv       (rx_dv),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.frame_done  (frame_done),
		.frame_drop  (frame_drop),
		.src_mac     (src_mac),
		.src_ip      (src_ip),
		.dst_ip      (dst_ip),
		.src_port    (src_port),
		.dst_port    (dst_port),
		.payload_len (payload_len),
		.word_count  (word_count)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Galois LFSR on x^16 + x^14 + x^13 + x^11 + 1 with one step per bit
	function automatic logic [7:0] rand_byte();
		logic [7:0] b;
		b = 8'h00;
		for (int i = 0; i < 8; i++) begin
			b = {b[6:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
		end
		return b;
	endfunction

	// Header checksum with the checksum field still zero
	function automatic logic [15:0] ip_checksum(udp_rx_pkg::ipv4_hdr_u h);
		logic [31:0] sum;
		sum = 32'd0;
		for (int i = 0; i < 10; i++)
			sum = sum + 32'(h.words[i]);
		sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
		sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
		return ~sum[15:0];
	endfunction

	// Expected RAM word as big-endian bytes with zero fill past the payload end
	function automatic logic [31:0] expected_word(int w);
		logic [31:0] word;
		word = 32'h0;
		for (int b = 0; b < 4; b++)
			word = {word[23:0], (4 * w + b < pay_q.size()) ? pay_q[4 * w + b] : 8'h00};
		return word;
	endfunction

	function automatic int expected_words(int len);
		return (len + 3) / 4;
	endfunction

	function automatic string strobe_name(int code);
		return (code == 1) ? "frame_done" : (code == 2) ? "frame_drop" : "no strobe";
	endfunction

	task automatic build_frame(input int len, input logic [47:0] dst, input logic [7:0] proto,
			input bit bad_csum, input bit bad_pre);
		udp_rx_pkg::ipv4_hdr_u ip;
		logic [63:0]           udp;
		frame_q.delete();
		pay_q.delete();
		exp_src_mac  = 48'h0200_c0a8_0000 + 48'(len);
		exp_src_ip   = 32'hc0a8_6400 + 32'(len);
		exp_dst_ip   = 32'hc0a8_0a00 + 32'(len);
		exp_src_port = 16'd5000 + 16'(len);
		exp_dst_port = 16'd7 + 16'(len);
		exp_len      = 16'(len);
		exp_wc       = (RAM_AW + 1)'(expected_words(len));
		for (int i = 0; i < 7; i++)
			frame_q.push_back((bad_pre && i == 3) ? 8'h57 : 8'h55);
		frame_q.push_back(8'hd5);
		for (int i = 5; i >= 0; i--)
			frame_q.push_back(dst[8 * i +: 8]);
		for (int i = 5; i >= 0; i--)
			frame_q.push_back(exp_src_mac[8 * i +: 8]);
		frame_q.push_back(8'h08);                  // IPv4 EtherType
		frame_q.push_back(8'h00);
		ip = '0;
		ip.hdr.version      = 4'd4;
		ip.hdr.ihl          = 4'd5;
		ip.hdr.total_length = 16'(28 + len);
		ip.hdr.id           = 16'(len);
		ip.hdr.flags_frag   = 16'h4000;            // Don't fragment
		ip.hdr.ttl          = 8'd64;
		ip.hdr.protocol     = proto;
		ip.hdr.src_ip       = exp_src_ip;
		ip.hdr.dst_ip       = exp_dst_ip;
		ip.hdr.checksum     = ip_checksum(ip) ^ (bad_csum ? 16'h0100 : 16'h0000);
		for (int i = 9; i >= 0; i--) begin
			frame_q.push_back(ip.words[i][15:8]);
			frame_q.push_back(ip.words[i][7:0]);
		end
		udp = {exp_src_port, exp_dst_port, 16'(8 + len), 16'h0000};
		for (int i = 7; i >= 0; i--)
			frame_q.push_back(udp[8 * i +: 8]);
		for (int i = 0; i < len; i++) begin
			pay_q.push_back(rand_byte());
			frame_q.push_back(pay_q[i]);
		end
		for (int i = 0; i < 4; i++)
			frame_q.push_back(rand_byte());        // FCS, ignored by the DUT
	endtask

	task automatic send_bytes(input int count);
		for (int i = 0; i < count; i++) begin
			@(negedge clk);
			rx_dv = 1'b1;
			rxd   = frame_q[i];
		end
		@(negedge clk);
		rx_dv = 1'b0;
		rxd   = 8'h00;
		repeat (12) @(negedge clk);                // Inter-frame gap
	endtask

	// 1 for frame_done, 2 for frame_drop, 0 when nothing came in time
	task automatic wait_strobe(input int done0, input int drop0, output int res);
		int n;
		n   = 0;
		res = 0;
		while (res == 0 && n < TIMEOUT) begin
			@(posedge clk);
			n++;
			if (done_cnt != done0)
				res = 1;
			else if (drop_cnt != drop0)
				res = 2;
		end
	endtask

	task automatic report_mismatch(input string what, input logic [63:0] e, input logic [63:0] a);
		$display("CHECK FAILED %s %s expected %0h actual %0h", test_name, what, e, a);
	endtask

	// Held header outputs against the frame just built
	always @(negedge clk) begin
		if (!reset && frame_drop)
			drop_cnt = drop_cnt + 1;
		if (!reset && frame_done) begin
			done_cnt = done_cnt + 1;
			if (src_mac !== exp_src_mac) begin
				report_mismatch("src_mac", 64'(exp_src_mac), 64'(src_mac));
				mon_errs = mon_errs + 1;
			end
			if (src_ip !== exp_src_ip || dst_ip !== exp_dst_ip) begin
				report_mismatch("ip_addr", {exp_src_ip, exp_dst_ip}, {src_ip, dst_ip});
				mon_errs = mon_errs + 1;
			end
			if (src_port !== exp_src_port || dst_port !== exp_dst_port) begin
				report_mismatch("ports", 64'({exp_src_port, exp_dst_port}),
					64'({src_port, dst_port}));
				mon_errs = mon_errs + 1;
			end
			if (payload_len !== exp_len) begin
				report_mismatch("payload_len", 64'(exp_len), 64'(payload_len));
				mon_errs = mon_errs + 1;
			end
			if (word_count !== exp_wc) begin
				report_mismatch("word_count", 64'(exp_wc), 64'(word_count));
				mon_errs = mon_errs + 1;
			end
		end
	end

	task automatic run_test(input string name, input int len, input logic [47:0] dst,
			input logic [7:0] proto, input bit bad_csum, input bit bad_pre, input int cut,
			input int expect_res);
		int errs;
		int d0;
		int p0;
		int m0;
		int res;
		test_name = name;
		build_frame(len, dst, proto, bad_csum, bad_pre);
		d0 = done_cnt;
		p0 = drop_cnt;
		m0 = mon_errs;
		send_bytes(cut > 0 ? cut : frame_q.size());
		wait_strobe(d0, p0, res);
		errs = 0;
		if (res != expect_res) begin
			$display("%s: expected %s but saw %s", name, strobe_name(expect_res),
				strobe_name(res));
			errs++;
		end else if (res == 1) begin
			for (int w = 0; w < expected_words(len); w++) begin
				@(negedge clk);
				rd_addr = RAM_AW'(w);
				@(negedge clk);                    // Registered read
				if (rd_data !== expected_word(w)) begin
					report_mismatch($sformatf("ram[%0d]", w), 64'(expected_word(w)),
						64'(rd_data));
					errs++;
				end
			end
		end
		errs += mon_errs - m0;
		tests_run++;
		if (errs != 0)
			tests_bad++;
		$display("%-16s %s", name, (errs == 0) ? "ok" : "FAILED");
	endtask

	initial begin
		reset   = 1'b1;
		rxd     = 8'h00;
		rx_dv   = 1'b0;
		rd_addr = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		run_test("good_64", 64, BOARD_MAC, udp_rx_pkg::IP_PROTO_UDP, 1'b0, 1'b0, 0, 1);
		for (int n = 1; n <= 8; n++)
			run_test($sformatf("len_%0d", n), n, BOARD_MAC, udp_rx_pkg::IP_PROTO_UDP,
				1'b0, 1'b0, 0, 1);
		run_test("wrong_mac", 40, BOARD_MAC ^ 48'h1, udp_rx_pkg::IP_PROTO_UDP, 1'b0, 1'b0, 0, 2);
		run_test("bad_checksum", 40, BOARD_MAC, udp_rx_pkg::IP_PROTO_UDP, 1'b1, 1'b0, 0, 2);
		run_test("proto_tcp", 40, BOARD_MAC, 8'd6, 1'b0, 1'b0, 0, 2);
		run_test("cut_payload", 40, BOARD_MAC, udp_rx_pkg::IP_PROTO_UDP, 1'b0, 1'b0, 60, 2);
		run_test("after_cut", 23, BOARD_MAC, udp_rx_pkg::IP_PROTO_UDP, 1'b0, 1'b0, 0, 1);
		run_test("bad_preamble", 40, BOARD_MAC, udp_rx_pkg::IP_PROTO_UDP, 1'b0, 1'b1, 0, 0);
		run_test("after_preamble", 17, BOARD_MAC, udp_rx_pkg::IP_PROTO_UDP, 1'b0, 1'b0, 0, 1);
		$display("%0d tests run, %0d ok, %0d failed", tests_run, tests_run - tests_bad,
			tests_bad);
		if (tests_bad == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/rx_byte_if.sv ====
`default_nettype none

// One received byte per cycle, labelled with its place in the frame
interface rx_byte_if;

	logic                 valid;                   // Byte present this cycle
	logic [7:0]           data;
	udp_rx_pkg::rx_sect_e sect;                    // Frame section of the byte
	logic [4:0]           idx;                     // Byte index in section
	logic                 last;                    // Final payload byte

	modport src (
		output valid, data, sect, idx, last
	);

	modport sink (
		input valid, data, sect, idx, last
	);

endinterface

`default_nettype wire

// ==== hdl/udp_hdr_capture.sv ====
`default_nettype none

module udp_hdr_capture #(
	parameter logic [47:0] BOARD_MAC = 48'h000a_3501_fec0
) (
	input  wire logic        clk,
	input  wire logic        reset,
	rx_byte_if.sink          bus,
	output logic             hdr_ok,
	output logic [15:0]      payload_len,
	output logic [47:0]      src_mac,
	output logic [31:0]      src_ip,
	output logic [31:0]      dst_ip,
	output logic [15:0]      src_port,
	output logic [15:0]      dst_port
);

	logic [47:0]           dst_mac_q;
	logic [47:0]           src_mac_q;
	logic [15:0]           eth_type;
	udp_rx_pkg::ipv4_hdr_u ip_hdr;
	logic [63:0]           udp_hdr;              // Ports, length, checksum
	logic [15:0]           udp_len;
	logic [19:0]           csum_sum;
	logic [16:0]           csum_fold;
	logic                  csum_ok;

	// Each byte lands at a fixed place given by idx
	always_ff @(posedge clk) begin
		if (bus.valid) begin
			case (bus.sect)
				udp_rx_pkg::sect_mac: begin
					if (bus.idx < 5'd6)
						dst_mac_q[47 - 8 * bus.idx -: 8] <= bus.data;
					else
						src_mac_q[95 - 8 * bus.idx -: 8] <= bus.data;
				end
				udp_rx_pkg::sect_type: eth_type[15 - 8 * bus.idx -: 8] <= bus.data;
				udp_rx_pkg::sect_ip:
					ip_hdr.words[9 - bus.idx[4:1]][15 - 8 * bus.idx[0] -: 8] <= bus.data;
				udp_rx_pkg::sect_udp:  udp_hdr[63 - 8 * bus.idx -: 8] <= bus.data;
				default: ;
			endcase
		end
	end

	// Outputs follow only frames that reach the payload
	always_ff @(posedge clk) begin
		if (bus.valid && bus.sect == udp_rx_pkg::sect_payload && bus.idx == 5'd0) begin
			src_mac  <= src_mac_q;
			src_ip   <= ip_hdr.hdr.src_ip;
			dst_ip   <= ip_hdr.hdr.dst_ip;
			src_port <= udp_hdr[63:48];
			dst_port <= udp_hdr[47:32];
		end
	end

	// One's complement sum over the ten header words
	always_comb begin
		csum_sum = 20'd0;
		for (int i = 0; i < 10; i++)
			csum_sum = csum_sum + 20'(ip_hdr.words[i]);
		csum_fold = {1'b0, csum_sum[15:0]} + 17'(csum_sum[19:16]);
	end

	assign csum_ok = (csum_fold[15:0] + 16'(csum_fold[16])) == 16'hffff;

	assign udp_len     = udp_hdr[31:16];
	assign payload_len = udp_len - 16'd8;      // Strip the UDP header

	assign hdr_ok = (dst_mac_q == BOARD_MAC)
		&& (eth_type == udp_rx_pkg::ETH_TYPE_IPV4)
		&& (ip_hdr.hdr.version == 4'd4)
		&& (ip_hdr.hdr.ihl == 4'd5)                // No options
		&& (ip_hdr.hdr.protocol == udp_rx_pkg::IP_PROTO_UDP)
		&& csum_ok
		&& (udp_len >= 16'd9);                     // At least one payload byte

	// Controller labelling must stay inside each section
	assert property (@(posedge clk) disable iff (reset)
		bus.valid && bus.sect != udp_rx_pkg::sect_payload |->
			(bus.sect == udp_rx_pkg::sect_mac && bus.idx < 5'd12)
			|| (bus.sect == udp_rx_pkg::sect_type && bus.idx < 5'd2)
			|| (bus.sect == udp_rx_pkg::sect_ip && bus.idx < 5'd20)
			|| (bus.sect == udp_rx_pkg::sect_udp && bus.idx < 5'd8));

endmodule

`default_nettype wire

// ==== hdl/udp_payload_ram.sv ====
`default_nettype none

module udp_payload_ram #(
	parameter int RAM_ADDR_WIDTH = 9
) (
	input  wire logic                      clk,
	input  wire logic                      wr_en,
	input  wire logic [RAM_ADDR_WIDTH-1:0] wr_addr,
	input  wire logic [31:0]               wr_data,
	input  wire logic [RAM_ADDR_WIDTH-1:0] rd_addr,
	output logic [31:0]                    rd_data
);

	logic [31:0] mem [2**RAM_ADDR_WIDTH];          // Maps to block RAM

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// Data one cycle after the address
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// ==== hdl/udp_rx_ctrl.sv ====
`default_nettype none

module udp_rx_ctrl (
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic [7:0]  rxd,
	input  wire logic        rx_dv,
	input  wire logic        hdr_ok,
	input  wire logic [15:0] payload_len,
	rx_byte_if.src           bus,
	output logic             frame_done,
	output logic             frame_drop
);

	typedef enum logic [2:0] {
		st_hunt,
		st_preamble,
		st_sfd,
		st_header,
		st_payload,
		st_skip,
		st_done
	} state_e;

	state_e               state;
	udp_rx_pkg::rx_sect_e sect;                    // Section of the next header byte
	logic [4:0]           cnt;                     // Preamble or section byte count
	logic [15:0]          pay_cnt;                 // Payload bytes taken so far
	logic [4:0]           sect_end;
	logic                 pay_last;
	logic                 done_pend;

	// Index of the final byte of each header section
	always_comb begin
		case (sect)
			udp_rx_pkg::sect_mac:  sect_end = 5'd11;
			udp_rx_pkg::sect_type: sect_end = 5'd1;
			udp_rx_pkg::sect_ip:   sect_end = 5'd19;
			default:               sect_end = 5'd7;
		endcase
	end

	assign pay_last = (pay_cnt == payload_len - 16'd1);

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= st_hunt;
			sect       <= udp_rx_pkg::sect_mac;
			cnt        <= 5'd0;
			pay_cnt    <= 16'd0;
			done_pend  <= 1'b0;
			frame_done <= 1'b0;
			frame_drop <= 1'b0;
			bus.valid  <= 1'b0;
		end else begin
			bus.valid  <= 1'b0;
			frame_drop <= 1'b0;
			done_pend  <= 1'b0;
			frame_done <= done_pend;               // Lines up with the last RAM write
			case (state)
				st_hunt: begin
					if (rx_dv) begin
						if (rxd == udp_rx_pkg::PREAMBLE_BYTE) begin
							cnt   <= 5'd1;
							state <= st_preamble;
						end else begin
							state <= st_skip;      // Joined mid-frame
						end
					end
				end
				st_preamble: begin
					if (!rx_dv) begin
						state <= st_hunt;
					end else if (rxd != udp_rx_pkg::PREAMBLE_BYTE) begin
						state <= st_skip;
					end else begin
						cnt <= cnt + 5'd1;
						if (cnt == 5'(udp_rx_pkg::PREAMBLE_COUNT - 1))
							state <= st_sfd;
					end
				end
				st_sfd: begin
					if (!rx_dv) begin
						state <= st_hunt;
					end else if (rxd == udp_rx_pkg::SFD_BYTE) begin
						sect  <= udp_rx_pkg::sect_mac;
						cnt   <= 5'd0;
						state <= st_header;
					end else begin
						state <= st_skip;
					end
				end
				st_header: begin
					if (!rx_dv) begin
						frame_drop <= 1'b1;        // Cut short inside the headers
						state      <= st_hunt;
					end else begin
						bus.valid <= 1'b1;
						bus.data  <= rxd;
						bus.sect  <= sect;
						bus.idx   <= cnt;
						bus.last  <= 1'b0;
						if (cnt == sect_end) begin
							cnt <= 5'd0;
							case (sect)
								udp_rx_pkg::sect_mac:  sect <= udp_rx_pkg::sect_type;
								udp_rx_pkg::sect_type: sect <= udp_rx_pkg::sect_ip;
								udp_rx_pkg::sect_ip:   sect <= udp_rx_pkg::sect_udp;
								default: begin
									sect    <= udp_rx_pkg::sect_payload;
									pay_cnt <= 16'd0;
									state   <= st_payload;
								end
							endcase
						end else begin
							cnt <= cnt + 5'd1;
						end
					end
				end
				st_payload: begin
					if (!rx_dv) begin
						frame_drop <= 1'b1;
						state      <= st_hunt;
					end else if (pay_cnt == 16'd0 && !hdr_ok) begin
						frame_drop <= 1'b1;        // Rejected on its first payload byte
						state      <= st_skip;
					end else begin
						bus.valid <= 1'b1;
						bus.data  <= rxd;
						bus.sect  <= sect;
						bus.idx   <= cnt;
						bus.last  <= pay_last;
						if (cnt != 5'd31)
							cnt <= cnt + 5'd1;     // Saturates since only zero marks the start
						pay_cnt <= pay_cnt + 16'd1;
						if (pay_last)
							state <= st_done;
					end
				end
				st_done: begin
					done_pend <= 1'b1;
					state     <= rx_dv ? st_skip : st_hunt;
				end
				st_skip: begin
					if (!rx_dv)
						state <= st_hunt;          // FCS and trailing bytes end here
				end
				default: state <= st_hunt;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		!(frame_done && frame_drop));

endmodule

`default_nettype wire

// ==== hdl/udp_rx_pkg.sv ====
`default_nettype none

package udp_rx_pkg;

	// Section a received byte belongs to
	typedef enum logic [2:0] {
		sect_mac,                                  // Dest and source MAC, 12 bytes
		sect_type,                                 // EtherType, 2 bytes
		sect_ip,                                   // IPv4 header, 20 bytes
		sect_udp,                                  // UDP header, 8 bytes
		sect_payload
	} rx_sect_e;

	localparam logic [15:0] ETH_TYPE_IPV4  = 16'h0800;
	localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;
	localparam logic [7:0]  PREAMBLE_BYTE  = 8'h55;
	localparam logic [7:0]  SFD_BYTE       = 8'hd5;
	localparam int          PREAMBLE_COUNT = 7;

	typedef struct packed {
		logic [3:0]  version;
		logic [3:0]  ihl;
		logic [7:0]  tos;
		logic [15:0] total_length;
		logic [15:0] id;
		logic [15:0] flags_frag;
		logic [7:0]  ttl;
		logic [7:0]  protocol;
		logic [15:0] checksum;
		logic [31:0] src_ip;
		logic [31:0] dst_ip;
	} ipv4_hdr_s;

	// Field view for decoding, word view for the checksum
	typedef union packed {
		ipv4_hdr_s        hdr;
		logic [9:0][15:0] words;                   // words[9] is the first on the wire
	} ipv4_hdr_u;

endpackage

`default_nettype wire

// ==== hdl/udp_rx_top.sv ====
`default_nettype none

module udp_rx_top #(
	parameter logic [47:0] BOARD_MAC      = 48'h000a_3501_fec0,
	parameter int          RAM_ADDR_WIDTH = 9
) (
	input  wire logic                      clk,
	input  wire logic                      reset,
	input  wire logic [7:0]                rxd,          // GMII receive data
	input  wire logic                      rx_dv,
	input  wire logic [RAM_ADDR_WIDTH-1:0] rd_addr,
	output wire logic [31:0]               rd_data,
	output wire logic                      frame_done,
	output wire logic                      frame_drop,
	output wire logic [47:0]               src_mac,
	output wire logic [31:0]               src_ip,
	output wire logic [31:0]               dst_ip,
	output wire logic [15:0]               src_port,
	output wire logic [15:0]               dst_port,
	output wire logic [15:0]               payload_len,
	output wire logic [RAM_ADDR_WIDTH:0]   word_count
);

	wire logic                      hdr_ok;
	wire logic                      wr_en;
	wire logic [RAM_ADDR_WIDTH-1:0] wr_addr;
	wire logic [31:0]               wr_data;

	rx_byte_if bus ();

	udp_rx_ctrl ctrl (
		.clk         (clk),
		.reset       (reset),
		.rxd         (rxd),
		.rx_dv       (rx_dv),
		.hdr_ok      (hdr_ok),
		.payload_len (payload_len),
		.bus         (bus.src),
		.frame_done  (frame_done),
		.frame_drop  (frame_drop)
	);

	udp_hdr_capture #(
		.BOARD_MAC (BOARD_MAC)
	) capture (
		.clk         (clk),
		.reset       (reset),
		.bus         (bus.sink),
		.hdr_ok      (hdr_ok),
		.payload_len (payload_len),
		.src_mac     (src_mac),
		.src_ip      (src_ip),
		.dst_ip      (dst_ip),
		.src_port    (src_port),
		.dst_port    (dst_port)
	);

	udp_word_packer #(
		.RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
	) packer (
		.clk        (clk),
		.reset      (reset),
		.bus        (bus.sink),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.word_count (word_count)
	);

	udp_payload_ram #(
		.RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
	) ram (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

endmodule

`default_nettype wire

// ==== hdl/udp_word_packer.sv ====
`default_nettype none

module udp_word_packer #(
	parameter int RAM_ADDR_WIDTH = 9
) (
	input  wire logic                    clk,
	input  wire logic                    reset,
	rx_byte_if.sink                      bus,
	output logic                         wr_en,
	output logic [RAM_ADDR_WIDTH-1:0]    wr_addr,
	output logic [31:0]                  wr_data,
	output logic [RAM_ADDR_WIDTH:0]      word_count
);

	logic [23:0]             acc;                  // Earlier bytes of the open word
	logic [1:0]              lane;                 // Byte position of the next byte
	logic [1:0]              pos;
	logic                    pay_byte;
	logic                    first;
	logic                    word_full;
	logic [31:0]             word;
	logic [RAM_ADDR_WIDTH:0] base;                 // Words already written this frame

	assign pay_byte  = bus.valid && bus.sect == udp_rx_pkg::sect_payload;
	assign first     = (bus.idx == 5'd0);
	assign pos       = first ? 2'd0 : lane;
	assign word_full = (pos == 2'd3) || bus.last;
	assign base      = first ? '0 : word_count;

	// Big-endian, missing low bytes are zero
	always_comb begin
		case (pos)
			2'd0:    word = {bus.data, 24'h000000};
			2'd1:    word = {acc[7:0], bus.data, 16'h0000};
			2'd2:    word = {acc[15:0], bus.data, 8'h00};
			default: word = {acc[23:0], bus.data};
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_en      <= 1'b0;
			lane       <= 2'd0;
			word_count <= '0;
		end else begin
			wr_en <= pay_byte && word_full;
			if (pay_byte) begin
				lane       <= pos + 2'd1;
				word_count <= word_full ? base + 1'b1 : base;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pay_byte) begin
			acc     <= {acc[15:0], bus.data};
			wr_data <= word;
			wr_addr <= base[RAM_ADDR_WIDTH-1:0];
		end
	end

	// A wrapped address would leave word_count one past the RAM size
	assert property (@(posedge clk) disable iff (reset)
		wr_en |-> word_count <= 2 ** RAM_ADDR_WIDTH);

endmodule

`default_nettype wire

// ==== project.f ====
hdl/udp_rx_pkg.sv
hdl/rx_byte_if.sv
hdl/udp_rx_ctrl.sv
hdl/udp_hdr_capture.sv
hdl/udp_word_packer.sv
hdl/udp_payload_ram.sv
hdl/udp_rx_top.sv
bench/udp_rx_tb.sv
